// File: Bender.yml
package:
  name: exu_top

sources:
  - logic/riscv_op_pkg.sv
  - logic/exu_cfg_pkg.sv
  - logic/alu_unit.sv
  - logic/muldiv_unit.sv
  - logic/wb_arbiter.sv
  - logic/exu_top.sv
  - target: test
    files:
      - verification/tb_exu_top.sv

// File: exu_top.f
logic/riscv_op_pkg.sv
logic/exu_cfg_pkg.sv
logic/alu_unit.sv
logic/muldiv_unit.sv
logic/wb_arbiter.sv
logic/exu_top.sv
verification/tb_exu_top.sv

// File: logic/alu_unit.sv
/*
 Single-cycle integer ALU of the execute back-end.
 Claims ALU-group ops only; the result and tag sit in a one-entry
 register until the writeback arbiter takes them.
*/
`timescale 1ns/1ps

module alu_unit (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 in_valid_i,
    input  riscv_op_pkg::op_e    in_op_i,
    input  riscv_op_pkg::word_t  in_a_i,
    input  riscv_op_pkg::word_t  in_b_i,
    input  exu_cfg_pkg::tag_t    in_tag_i,
    output logic                 in_ready_o,
    output logic                 res_valid_o,
    output riscv_op_pkg::word_t  res_data_o,
    output exu_cfg_pkg::tag_t    res_tag_o,
    input  logic                 res_ready_i
);

    logic                                 valid_q;
    riscv_op_pkg::word_t                  data_q;
    exu_cfg_pkg::tag_t                    tag_q;
    riscv_op_pkg::word_t                  alu_res;
    logic [riscv_op_pkg::SHAMT_W-1:0]     shamt;
    logic                                 accept;

    assign shamt = in_b_i[riscv_op_pkg::SHAMT_W-1:0];

    // room when empty or drained this cycle
    assign in_ready_o = !riscv_op_pkg::is_md_op(in_op_i) && (!valid_q || res_ready_i);
    assign accept     = in_valid_i && in_ready_o;

    always_comb begin
        case (in_op_i)
            riscv_op_pkg::OP_ADD:  alu_res = in_a_i + in_b_i;
            riscv_op_pkg::OP_SUB:  alu_res = in_a_i - in_b_i;
            riscv_op_pkg::OP_AND:  alu_res = in_a_i & in_b_i;
            riscv_op_pkg::OP_OR:   alu_res = in_a_i | in_b_i;
            riscv_op_pkg::OP_XOR:  alu_res = in_a_i ^ in_b_i;
            riscv_op_pkg::OP_SLL:  alu_res = in_a_i << shamt;
            riscv_op_pkg::OP_SRL:  alu_res = in_a_i >> shamt;
            riscv_op_pkg::OP_SRA:  alu_res = $unsigned($signed(in_a_i) >>> shamt); // sign fill
            riscv_op_pkg::OP_SLT: begin
                alu_res = riscv_op_pkg::word_t'($signed(in_a_i) < $signed(in_b_i));
            end
            riscv_op_pkg::OP_SLTU: alu_res = riscv_op_pkg::word_t'(in_a_i < in_b_i);
            default:               alu_res = '0; // mul/div codes never accepted here
        endcase
    end

    // valid flag of the holding register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (res_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= alu_res;
            tag_q  <= in_tag_i;
        end
    end

    assign res_valid_o = valid_q;
    assign res_data_o  = data_q;
    assign res_tag_o   = tag_q;

endmodule

// File: logic/exu_cfg_pkg.sv
/*
 Configuration of the execute back-end.
 Tag width, iteration count of the multiply/divide unit and its FSM states.
*/
package exu_cfg_pkg;

    localparam int TAG_W = 4;

    typedef logic [TAG_W-1:0] tag_t; // echoed with the result

    // one product or quotient bit per cycle
    localparam int MD_CYCLES = riscv_op_pkg::XLEN;

    // counter must reach MD_CYCLES itself
    typedef logic [$clog2(MD_CYCLES + 1)-1:0] md_cnt_t;

    localparam md_cnt_t MD_LAST = md_cnt_t'(MD_CYCLES);

    typedef enum logic [1:0] {
        MD_IDLE = 2'b00,
        MD_BUSY = 2'b01,
        MD_DONE = 2'b10
    } md_state_e;

endpackage

// File: logic/exu_top.sv
/*
 Execute and writeback back-end top level.
 Decoded ops with operand values and a tag enter under valid/ready, run in
 the ALU or the mul/div unit, and leave as one tagged result stream.
*/
`timescale 1ns/1ps

module exu_top (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 in_valid_i,
    input  riscv_op_pkg::op_e    in_op_i,
    input  riscv_op_pkg::word_t  in_a_i,
    input  riscv_op_pkg::word_t  in_b_i,
    input  exu_cfg_pkg::tag_t    in_tag_i,
    output logic                 in_ready_o,
    output logic                 out_valid_o,
    output riscv_op_pkg::word_t  out_data_o,
    output exu_cfg_pkg::tag_t    out_tag_o,
    input  logic                 out_ready_i
);

    // alu to arbiter
    logic                 alu_in_ready;
    logic                 alu_valid;
    logic                 alu_ready;
    riscv_op_pkg::word_t  alu_data;
    exu_cfg_pkg::tag_t    alu_tag;

    // mul/div to arbiter
    logic                 md_in_ready;
    logic                 md_valid;
    logic                 md_ready;
    riscv_op_pkg::word_t  md_data;
    exu_cfg_pkg::tag_t    md_tag;

    // only the unit owning the op group raises ready
    assign in_ready_o = alu_in_ready | md_in_ready;

    alu_unit u_alu (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .in_valid_i (in_valid_i),
        .in_op_i    (in_op_i),
        .in_a_i     (in_a_i),
        .in_b_i     (in_b_i),
        .in_tag_i   (in_tag_i),
        .in_ready_o (alu_in_ready),
        .res_valid_o(alu_valid),
        .res_data_o (alu_data),
        .res_tag_o  (alu_tag),
        .res_ready_i(alu_ready)
    );

    muldiv_unit u_muldiv (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .in_valid_i (in_valid_i),
        .in_op_i    (in_op_i),
        .in_a_i     (in_a_i),
        .in_b_i     (in_b_i),
        .in_tag_i   (in_tag_i),
        .in_ready_o (md_in_ready),
        .res_valid_o(md_valid),
        .res_data_o (md_data),
        .res_tag_o  (md_tag),
        .res_ready_i(md_ready)
    );

    wb_arbiter u_wb (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .alu_valid_i(alu_valid),
        .alu_data_i (alu_data),
        .alu_tag_i  (alu_tag),
        .alu_ready_o(alu_ready),
        .md_valid_i (md_valid),
        .md_data_i  (md_data),
        .md_tag_i   (md_tag),
        .md_ready_o (md_ready),
        .out_valid_o(out_valid_o),
        .out_data_o (out_data_o),
        .out_tag_o  (out_tag_o),
        .out_ready_i(out_ready_i)
    );

endmodule

// File: logic/muldiv_unit.sv
/*
 Iterative multiply/divide unit: shift-add multiplier and restoring divider.
 Accepts one mul/div-group op in MD_IDLE, iterates MD_CYCLES steps, then
 holds the result in MD_DONE until the arbiter takes it.
*/
`timescale 1ns/1ps

module muldiv_unit (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 in_valid_i,
    input  riscv_op_pkg::op_e    in_op_i,
    input  riscv_op_pkg::word_t  in_a_i,
    input  riscv_op_pkg::word_t  in_b_i,
    input  exu_cfg_pkg::tag_t    in_tag_i,
    output logic                 in_ready_o,
    output logic                 res_valid_o,
    output riscv_op_pkg::word_t  res_data_o,
    output exu_cfg_pkg::tag_t    res_tag_o,
    input  logic                 res_ready_i
);

    exu_cfg_pkg::md_state_e                state_q;
    exu_cfg_pkg::md_cnt_t                  cnt_q;   // number of the step in progress
    riscv_op_pkg::op_e                     op_q;
    exu_cfg_pkg::tag_t                     tag_q;
    logic [2*riscv_op_pkg::XLEN-1:0]       acc_q;   // product, or remainder in low word
    logic [2*riscv_op_pkg::XLEN-1:0]       shf_q;   // multiplicand shifting left / divisor
    riscv_op_pkg::word_t                   opr_q;   // multiplier, or dividend turning into quotient
    riscv_op_pkg::word_t                   md_result;
    logic [riscv_op_pkg::XLEN:0]           div_trial;
    logic [riscv_op_pkg::XLEN:0]           div_diff;
    logic                                  is_div;
    logic                                  last_step;
    logic                                  accept;

    assign in_ready_o = (state_q == exu_cfg_pkg::MD_IDLE) && riscv_op_pkg::is_md_op(in_op_i);
    assign accept     = in_valid_i && in_ready_o;
    assign last_step  = (cnt_q == exu_cfg_pkg::MD_LAST);
    assign is_div     = (op_q == riscv_op_pkg::OP_DIVU) || (op_q == riscv_op_pkg::OP_REMU);

    // restoring step: bring in next dividend bit, try to subtract
    // a zero divisor always succeeds, giving all-ones quotient and rem = dividend
    assign div_trial = {acc_q[riscv_op_pkg::XLEN-1:0], opr_q[riscv_op_pkg::XLEN-1]};
    assign div_diff  = div_trial - {1'b0, shf_q[riscv_op_pkg::XLEN-1:0]};

    always_comb begin
        case (op_q)
            riscv_op_pkg::OP_MULHU: md_result = acc_q[2*riscv_op_pkg::XLEN-1:riscv_op_pkg::XLEN];
            riscv_op_pkg::OP_DIVU:  md_result = opr_q;
            default:                md_result = acc_q[riscv_op_pkg::XLEN-1:0]; // mul, remu
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= exu_cfg_pkg::MD_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                exu_cfg_pkg::MD_IDLE: begin
                    if (accept) begin
                        state_q <= exu_cfg_pkg::MD_BUSY;
                        cnt_q   <= exu_cfg_pkg::md_cnt_t'(1);
                    end
                end
                exu_cfg_pkg::MD_BUSY: begin
                    if (last_step) begin
                        state_q <= exu_cfg_pkg::MD_DONE; // last step done in this cycle
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                exu_cfg_pkg::MD_DONE: begin
                    if (res_ready_i) begin
                        state_q <= exu_cfg_pkg::MD_IDLE;
                    end
                end
                default: state_q <= exu_cfg_pkg::MD_IDLE;
            endcase
        end
    end

    // datapath, frozen outside MD_BUSY so the result holds in MD_DONE
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q  <= in_op_i;
            tag_q <= in_tag_i;
            acc_q <= '0;
            shf_q <= {{riscv_op_pkg::XLEN{1'b0}}, in_b_i};
            opr_q <= in_a_i;
        end else if (state_q == exu_cfg_pkg::MD_BUSY) begin
            if (is_div) begin
                if (div_diff[riscv_op_pkg::XLEN]) begin
                    acc_q <= {{riscv_op_pkg::XLEN{1'b0}}, div_trial[riscv_op_pkg::XLEN-1:0]};
                end else begin
                    acc_q <= {{riscv_op_pkg::XLEN{1'b0}}, div_diff[riscv_op_pkg::XLEN-1:0]};
                end
                opr_q <= {opr_q[riscv_op_pkg::XLEN-2:0], ~div_diff[riscv_op_pkg::XLEN]};
            end else begin
                if (opr_q[0]) begin
                    acc_q <= acc_q + shf_q;
                end
                shf_q <= shf_q << 1;
                opr_q <= opr_q >> 1;
            end
        end
    end

    assign res_valid_o = (state_q == exu_cfg_pkg::MD_DONE);
    assign res_data_o  = md_result;
    assign res_tag_o   = tag_q;

endmodule

// File: logic/riscv_op_pkg.sv
/*
 Operation encoding and data width shared by the execute back-end.
 Every unit decodes its own group from op_e through is_md_op().
*/
package riscv_op_pkg;

    localparam int XLEN    = 32;
    localparam int SHAMT_W = $clog2(XLEN); // shift amount bits taken from operand b

    typedef logic [XLEN-1:0] word_t;

    // alu ops fill the low codes, mul/div ops the top block 4'b11xx
    // ten alu ops run past 4'h7, so the group needs the top two bits
    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_AND   = 4'h2,
        OP_OR    = 4'h3,
        OP_XOR   = 4'h4,
        OP_SLL   = 4'h5,
        OP_SRL   = 4'h6,
        OP_SRA   = 4'h7,
        OP_SLT   = 4'h8,
        OP_SLTU  = 4'h9,
        OP_MUL   = 4'hC,  // low word of product
        OP_MULHU = 4'hD,  // high word, both unsigned
        OP_DIVU  = 4'hE,
        OP_REMU  = 4'hF
    } op_e;

    // group decode, 1 for the multiply/divide unit
    function automatic logic is_md_op(op_e op);
        return op[3:2] == 2'b11;
    endfunction

endpackage

// File: logic/wb_arbiter.sv
/*
 Writeback arbiter of the execute back-end.
 Merges the ALU and mul/div result streams into one registered output,
 the long mul/div result winning when both wait.
*/
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 alu_valid_i,
    input  riscv_op_pkg::word_t  alu_data_i,
    input  exu_cfg_pkg::tag_t    alu_tag_i,
    output logic                 alu_ready_o,
    input  logic                 md_valid_i,
    input  riscv_op_pkg::word_t  md_data_i,
    input  exu_cfg_pkg::tag_t    md_tag_i,
    output logic                 md_ready_o,
    output logic                 out_valid_o,
    output riscv_op_pkg::word_t  out_data_o,
    output exu_cfg_pkg::tag_t    out_tag_o,
    input  logic                 out_ready_i
);

    logic                 valid_q;
    riscv_op_pkg::word_t  data_q;
    exu_cfg_pkg::tag_t    tag_q;
    logic                 load_en;
    logic                 md_take;

    // output register free or draining this cycle
    assign load_en = !valid_q || out_ready_i;

    assign md_ready_o  = load_en;
    assign alu_ready_o = load_en && !md_valid_i; // alu waits behind a pending mul/div
    assign md_take     = md_valid_i && md_ready_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (load_en) begin
            valid_q <= md_valid_i || alu_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (md_take) begin
            data_q <= md_data_i;
            tag_q  <= md_tag_i;
        end else if (alu_valid_i && alu_ready_o) begin
            data_q <= alu_data_i;
            tag_q  <= alu_tag_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;
    assign out_tag_o   = tag_q;

endmodule

// File: verification/tb_exu_top.sv
/*
 Testbench of the execute back-end. Random ALU and mul/div ops from a fixed
 seed go in under valid/ready, a reference model enters each result in a
 table by tag at the input handshake, and every output handshake is checked
 against that table, also under random back-pressure.
*/
`timescale 1ns/1ps

module tb_exu_top;

    localparam int HALF_PERIOD = 50;
    localparam int SETTLE      = 10; // sample point ahead of the rising edge
    localparam int N_ALU       = 200;
    localparam int N_MD        = 60;
    localparam int N_MIX       = 120;
    localparam int TOTAL_OPS   = 1 + N_ALU + N_MD + N_MIX + 2;
    localparam int ALU_LAT     = 2; // input to output handshake, no back-pressure
    localparam int MD_LAT      = exu_cfg_pkg::MD_CYCLES + 2;
    localparam int TIMEOUT     = TOTAL_OPS * MD_LAT * 4 + 500;
    localparam int N_TAGS      = 2 ** exu_cfg_pkg::TAG_W;

    logic                 clk;
    logic                 arst_n_i;
    logic                 in_valid_i;
    riscv_op_pkg::op_e    in_op_i;
    riscv_op_pkg::word_t  in_a_i;
    riscv_op_pkg::word_t  in_b_i;
    exu_cfg_pkg::tag_t    in_tag_i;
    logic                 in_ready_o;
    logic                 out_valid_o;
    riscv_op_pkg::word_t  out_data_o;
    exu_cfg_pkg::tag_t    out_tag_o;
    logic                 out_ready_i;

    // scoreboard indexed by tag
    logic                 exp_valid [N_TAGS];
    riscv_op_pkg::word_t  exp_data  [N_TAGS];
    exu_cfg_pkg::tag_t    out_order [$];  // tags in the order they left
    int                   out_cycle [$];  // cycle count at each output handshake
    exu_cfg_pkg::tag_t    next_tag;
    integer               seed;
    string                cur_test;
    int                   value_errors;
    int                   other_errors;
    int                   in_flight;
    int                   accept_waits;   // cycles the last op waited for in_ready_o
    int                   fire_cycle;     // cycle count at the last input handshake
    int                   cycle_cnt;
    logic                 bp_mode;        // random out_ready_i
    logic                 hold_q;         // output stalled at the last sample
    riscv_op_pkg::word_t  hold_data;
    exu_cfg_pkg::tag_t    hold_tag;

    exu_top dut (
        .clk, .arst_n_i, .in_valid_i, .in_op_i, .in_a_i, .in_b_i, .in_tag_i,
        .in_ready_o, .out_valid_o, .out_data_o, .out_tag_o, .out_ready_i
    );

    initial clk = 1'b0;
    always #HALF_PERIOD clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT) begin
            $display("timeout: run did not end within %0d cycles", TIMEOUT);
            $display("Finished with errors");
            $finish;
        end
    end

    // reference results from the RISC-V rules
    function automatic riscv_op_pkg::word_t compute_expected(riscv_op_pkg::op_e op,
                                                              riscv_op_pkg::word_t a,
                                                              riscv_op_pkg::word_t b);
        logic [4:0]                       sh;
        logic [2*riscv_op_pkg::XLEN-1:0]  prod;
        riscv_op_pkg::word_t              ones;
        riscv_op_pkg::word_t              sign;
        riscv_op_pkg::word_t              fill;
        sh   = b[4:0];
        prod = {{riscv_op_pkg::XLEN{1'b0}}, a} * {{riscv_op_pkg::XLEN{1'b0}}, b};
        ones = '1;
        sign = {1'b1, {(riscv_op_pkg::XLEN - 1){1'b0}}};
        fill = {riscv_op_pkg::XLEN{a[riscv_op_pkg::XLEN-1]}};
        case (op)
            riscv_op_pkg::OP_ADD:   return a + b;
            riscv_op_pkg::OP_SUB:   return a - b;
            riscv_op_pkg::OP_AND:   return a & b;
            riscv_op_pkg::OP_OR:    return a | b;
            riscv_op_pkg::OP_XOR:   return a ^ b;
            riscv_op_pkg::OP_SLL:   return a << sh;
            riscv_op_pkg::OP_SRL:   return a >> sh;
            riscv_op_pkg::OP_SRA:   return (a >> sh) | (fill & ~(ones >> sh));
            riscv_op_pkg::OP_SLT:   return riscv_op_pkg::word_t'((a ^ sign) < (b ^ sign));
            riscv_op_pkg::OP_SLTU:  return riscv_op_pkg::word_t'(a < b);
            riscv_op_pkg::OP_MUL:   return prod[riscv_op_pkg::XLEN-1:0];
            riscv_op_pkg::OP_MULHU: return prod[2*riscv_op_pkg::XLEN-1:riscv_op_pkg::XLEN];
            riscv_op_pkg::OP_DIVU:  return (b == '0) ? ones : a / b;
            riscv_op_pkg::OP_REMU:  return (b == '0) ? a : a % b;
            default:                return 'x;
        endcase
    endfunction

    function automatic riscv_op_pkg::word_t rand_word();
        return $random(seed);
    endfunction

    // sample just ahead of the rising edge, then move on to the falling edge
    task automatic step_cycle(output logic in_fire);
        exu_cfg_pkg::tag_t    t;
        riscv_op_pkg::word_t  r;
        #(HALF_PERIOD - SETTLE);
        in_fire = in_valid_i && in_ready_o;
        if (in_fire) begin
            fire_cycle = cycle_cnt;
        end
        if (hold_q) begin
            assert (out_valid_o && out_tag_o == hold_tag && out_data_o == hold_data) else begin
                $display("CHECK FAILED %s stall hold: expected %0d/%h, actual %b %0d/%h",
                         cur_test, hold_tag, hold_data, out_valid_o, out_tag_o, out_data_o);
                value_errors++;
            end
        end
        hold_q    = out_valid_o && !out_ready_i;
        hold_data = out_data_o;
        hold_tag  = out_tag_o;
        if (out_valid_o && out_ready_i) begin
            t = out_tag_o;
            out_order.push_back(t);
            out_cycle.push_back(cycle_cnt);
            assert (exp_valid[t]) else begin
                $display("unexpected result: tag %0d was not in flight", t);
                other_errors++;
            end
            if (exp_valid[t]) begin
                assert (out_data_o == exp_data[t]) else begin
                    $display("CHECK FAILED %s tag %0d: expected %h, actual %h",
                             cur_test, t, exp_data[t], out_data_o);
                    value_errors++;
                end
                exp_valid[t] = 1'b0;
                in_flight--;
            end
        end
        @(negedge clk);
        if (bp_mode) begin
            r           = rand_word();
            out_ready_i = r[0]; // low about half the time
        end
    endtask

    // offer one op until it is taken, then enter its result in the table
    task automatic send_op(input riscv_op_pkg::op_e op, input riscv_op_pkg::word_t a,
                           input riscv_op_pkg::word_t b);
        logic fire;
        in_valid_i   = 1'b1;
        in_op_i      = op;
        in_a_i       = a;
        in_b_i       = b;
        in_tag_i     = next_tag;
        accept_waits = 0;
        step_cycle(fire);
        while (!fire) begin
            accept_waits++;
            step_cycle(fire);
        end
        assert (!exp_valid[next_tag]) else begin
            $display("tag %0d accepted again while still in flight", next_tag);
            other_errors++;
        end
        exp_valid[next_tag] = 1'b1;
        exp_data[next_tag]  = compute_expected(op, a, b);
        in_flight++;
        next_tag++;         // wraps at 16
        in_valid_i = 1'b0;
    endtask

    // let everything in flight leave, then report results that never came
    task automatic drain();
        logic fire;
        int   n;
        int   t;
        n = 0;
        while (in_flight > 0 && n < 4 * MD_LAT) begin
            step_cycle(fire);
            n++;
        end
        for (t = 0; t < N_TAGS; t++) begin
            assert (!exp_valid[t]) else begin
                $display("lost result: tag %0d of %s never left the DUT", t, cur_test);
                other_errors++;
            end
            exp_valid[t] = 1'b0;
        end
        in_flight = 0;
    endtask

    initial begin
        riscv_op_pkg::word_t  a;
        riscv_op_pkg::word_t  b;
        riscv_op_pkg::word_t  r;
        riscv_op_pkg::op_e    op;
        exu_cfg_pkg::tag_t    tag_md;
        exu_cfg_pkg::tag_t    tag_alu;
        int                   md_fire;
        int                   alu_fire;
        logic                 fire;
        logic                 order_ok;
        int                   i;
        seed         = 32'ha6fe_aff6;
        cycle_cnt    = 0;
        value_errors = 0;
        other_errors = 0;
        in_flight    = 0;
        accept_waits = 0;
        fire_cycle   = 0;
        next_tag     = '0;
        bp_mode      = 1'b0;
        hold_q       = 1'b0;
        hold_data    = '0;
        hold_tag     = '0;
        cur_test     = "reset";
        for (i = 0; i < N_TAGS; i++) begin
            exp_valid[i] = 1'b0;
        end
        arst_n_i    = 1'b0;
        in_valid_i  = 1'b0;
        in_op_i     = riscv_op_pkg::OP_ADD;
        in_a_i      = '0;
        in_b_i      = '0;
        in_tag_i    = '0;
        out_ready_i = 1'b1;
        repeat (5) @(negedge clk);
        arst_n_i = 1'b1;

        // idle after reset, first op taken at once
        assert (!out_valid_o) else begin
            $display("out_valid_o high right after reset");
            other_errors++;
        end
        a = rand_word();
        b = rand_word();
        send_op(riscv_op_pkg::OP_ADD, a, b);
        assert (accept_waits == 0) else begin
            $display("in_ready_o low for the first op after reset");
            other_errors++;
        end
        drain();

        cur_test = "alu_random";
        for (i = 0; i < N_ALU; i++) begin
            r = rand_word();
            a = rand_word();
            b = rand_word();
            send_op(riscv_op_pkg::op_e'(4'(r % 10)), a, b);
        end
        drain();

        // zero divisors and all-ones operands mixed in
        cur_test = "muldiv_random";
        for (i = 0; i < N_MD; i++) begin
            a = rand_word();
            b = rand_word();
            case ((i / 4) % 5)
                0: b = '0;
                1: a = '1;
                2: begin
                    a = '1;
                    b = '1;
                end
                3: b = b & 32'h0000_00ff; // small divisor, wide quotient
                default: ;
            endcase
            send_op(riscv_op_pkg::op_e'(4'(riscv_op_pkg::OP_MUL) + 4'(i % 4)), a, b);
        end
        drain();

        cur_test = "mixed_backpressure";
        bp_mode  = 1'b1;
        for (i = 0; i < N_MIX; i++) begin
            r = rand_word();
            a = rand_word();
            b = rand_word();
            if (r[1:0] == 2'b00) begin
                op = riscv_op_pkg::op_e'(4'(riscv_op_pkg::OP_MUL) + 4'(r[3:2]));
            end else begin
                op = riscv_op_pkg::op_e'(4'(r[15:8] % 10));
            end
            send_op(op, a, b);
            if (r[18:16] == 3'b000) begin
                step_cycle(fire); // gap on the input side
            end
        end
        bp_mode     = 1'b0;
        out_ready_i = 1'b1;
        drain();

        // alu op right behind a mul/div op leaves first
        cur_test = "md_then_alu";
        out_order.delete();
        out_cycle.delete();
        a       = rand_word();
        b       = rand_word();
        tag_md  = next_tag;
        send_op(riscv_op_pkg::OP_MULHU, a, b);
        md_fire = fire_cycle;
        tag_alu = next_tag;
        send_op(riscv_op_pkg::OP_SRA, a, b);
        alu_fire = fire_cycle;
        assert (accept_waits == 0) else begin
            $display("alu op stalled behind the mul/div op");
            other_errors++;
        end
        drain();
        order_ok = out_order.size() == 2 && out_order[0] == tag_alu && out_order[1] == tag_md;
        assert (order_ok) else begin
            $display("alu result did not leave ahead of the earlier mul/div result");
            other_errors++;
        end
        if (order_ok) begin
            assert (out_cycle[0] - alu_fire == ALU_LAT) else begin
                $display("CHECK FAILED %s alu latency: expected %0d, actual %0d",
                         cur_test, ALU_LAT, out_cycle[0] - alu_fire);
                value_errors++;
            end
            assert (out_cycle[1] - md_fire == MD_LAT) else begin
                $display("CHECK FAILED %s mul/div latency: expected %0d, actual %0d",
                         cur_test, MD_LAT, out_cycle[1] - md_fire);
                value_errors++;
            end
        end

        $display("run done after %0d cycles: %0d value errors, %0d other errors",
                 cycle_cnt, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
